/* source/vdma_reg_pkg.sv */
// video dma register map

package vdma_reg_pkg;

    // ------------------------------------------------------------------------
    //  wishbone bus
    // ------------------------------------------------------------------------
    localparam int wb_adr_width = 8;
    localparam int wb_dat_width = 32;
    localparam int wb_sel_width = 4;

    localparam logic [wb_dat_width-1:0] core_id      = 32'h5644_4d31;
    localparam logic [wb_dat_width-1:0] core_version = 32'h0001_0000;

    // ------------------------------------------------------------------------
    //  register offsets, in words
    // ------------------------------------------------------------------------
    localparam logic [wb_adr_width-1:0] adr_core_id      = 8'h00;
    localparam logic [wb_adr_width-1:0] adr_core_version = 8'h01;
    localparam logic [wb_adr_width-1:0] adr_ctl_control  = 8'h04;
    localparam logic [wb_adr_width-1:0] adr_ctl_status   = 8'h05;
    localparam logic [wb_adr_width-1:0] adr_ctl_index    = 8'h06;
    localparam logic [wb_adr_width-1:0] adr_param_addr   = 8'h08;
    localparam logic [wb_adr_width-1:0] adr_param_stride = 8'h09;
    localparam logic [wb_adr_width-1:0] adr_param_width  = 8'h0a;
    localparam logic [wb_adr_width-1:0] adr_param_height = 8'h0b;
    localparam logic [wb_adr_width-1:0] adr_param_arlen  = 8'h0f;

    // control register bits
    localparam int ctl_bit_enable  = 0;
    localparam int ctl_bit_update  = 1;
    localparam int ctl_bit_oneshot = 2;
    localparam int ctl_width       = 3;

    localparam int index_width = 8;

endpackage

/* source/vdma_bus_pkg.sv */
// video dma bus types

package vdma_bus_pkg;

    localparam int addr_width   = 32;
    localparam int data_size    = 2;
    localparam int data_width   = 8 << data_size;
    localparam int len_width    = 8;
    localparam int stride_width = 16;
    localparam int h_width      = 12;
    localparam int v_width      = 12;

    // word aligned addresses only
    localparam logic [addr_width-1:0] addr_mask = ~((addr_width'(1) << data_size) - 1);

    // fixed read channel attributes
    localparam logic [2:0] ar_size   = 3'(data_size);
    localparam logic [1:0] ar_burst  = 2'b01;
    localparam logic [3:0] ar_cache  = 4'b0001;
    localparam logic [0:0] ar_lock   = 1'b0;
    localparam logic [2:0] ar_prot   = 3'b000;
    localparam logic [3:0] ar_qos    = 4'b0000;
    localparam logic [3:0] ar_region = 4'b0000;

    typedef struct packed {
        logic [addr_width-1:0]   addr;
        logic [stride_width-1:0] stride;
        logic [h_width-1:0]      width;
        logic [v_width-1:0]      height;
        logic [len_width-1:0]    arlen;
    } frame_cfg_t;

    typedef struct packed {
        logic [addr_width-1:0] araddr;
        logic [len_width-1:0]  arlen;
        logic                  arvalid;
    } axi_ar_t;

    typedef struct packed {
        logic [data_width-1:0] rdata;
        logic                  rlast;
        logic                  rvalid;
    } axi_r_t;

    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic                  tuser;
        logic                  tlast;
        logic                  tvalid;
    } axis_t;

endpackage

/* source/vdma_regs.sv */
// video dma register block

`timescale 1ns/10ps

module vdma_regs (
    input  logic                                  s_wb_clk_i,
    input  logic                                  s_wb_rst_i,
    input  logic [vdma_reg_pkg::wb_adr_width-1:0] s_wb_adr_i,
    input  logic [vdma_reg_pkg::wb_dat_width-1:0] s_wb_dat_i,
    output logic [vdma_reg_pkg::wb_dat_width-1:0] s_wb_dat_o,
    input  logic                                  s_wb_we_i,
    input  logic [vdma_reg_pkg::wb_sel_width-1:0] s_wb_sel_i,
    input  logic                                  s_wb_stb_i,
    output logic                                  s_wb_ack_o,
    input  logic                                  busy_i,
    input  logic                                  frame_done_i,
    output logic                                  enable_o,
    output logic                                  update_o,
    output vdma_bus_pkg::frame_cfg_t              cfg_o,
    output logic                                  irq_o
);
    import vdma_reg_pkg::*;
    import vdma_bus_pkg::*;

    logic [ctl_width-1:0]   ctl_q;
    logic [index_width-1:0] index_q;
    logic                   irq_q;
    frame_cfg_t             cfg_q;

    function automatic logic [wb_dat_width-1:0] byte_mask(
        input logic [wb_dat_width-1:0] org,
        input logic [wb_dat_width-1:0] wdat,
        input logic [wb_sel_width-1:0] sel
    );
        logic [wb_dat_width-1:0] res;
        for (int i = 0; i < wb_dat_width; i++) begin
            res[i] = sel[i / 8] ? wdat[i] : org[i];
        end
        return res;
    endfunction

    // ------------------------------------------------------------------------
    //  register write and frame end handling
    // ------------------------------------------------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            ctl_q   <= '0;
            index_q <= '0;
            irq_q   <= 1'b0;
            cfg_q   <= '0;
        end else begin
            if (s_wb_stb_i && s_wb_we_i) begin
                case (s_wb_adr_i)
                    adr_ctl_control: begin
                        ctl_q <= ctl_width'(byte_mask(wb_dat_width'(ctl_q), s_wb_dat_i,
                                                      s_wb_sel_i));
                    end
                    adr_param_addr: begin
                        cfg_q.addr <= byte_mask(cfg_q.addr, s_wb_dat_i, s_wb_sel_i) & addr_mask;
                    end
                    adr_param_stride: begin
                        cfg_q.stride <= stride_width'(byte_mask(wb_dat_width'(cfg_q.stride),
                                                                s_wb_dat_i, s_wb_sel_i))
                                        & stride_width'(addr_mask);
                    end
                    adr_param_width: begin
                        cfg_q.width <= h_width'(byte_mask(wb_dat_width'(cfg_q.width),
                                                          s_wb_dat_i, s_wb_sel_i));
                    end
                    adr_param_height: begin
                        cfg_q.height <= v_width'(byte_mask(wb_dat_width'(cfg_q.height),
                                                           s_wb_dat_i, s_wb_sel_i));
                    end
                    adr_param_arlen: begin
                        cfg_q.arlen <= len_width'(byte_mask(wb_dat_width'(cfg_q.arlen),
                                                            s_wb_dat_i, s_wb_sel_i));
                    end
                    default: ;
                endcase
            end

            // frame end wins over a write in the same cycle
            irq_q <= frame_done_i;
            if (frame_done_i) begin
                index_q               <= index_q + 1'b1;
                ctl_q[ctl_bit_update] <= 1'b0;
                if (ctl_q[ctl_bit_oneshot]) begin
                    ctl_q[ctl_bit_enable]  <= 1'b0;
                    ctl_q[ctl_bit_oneshot] <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    //  register read
    // ------------------------------------------------------------------------
    always_comb begin
        case (s_wb_adr_i)
            adr_core_id:      s_wb_dat_o = core_id;
            adr_core_version: s_wb_dat_o = core_version;
            adr_ctl_control:  s_wb_dat_o = wb_dat_width'(ctl_q);
            adr_ctl_status:   s_wb_dat_o = wb_dat_width'(busy_i);
            adr_ctl_index:    s_wb_dat_o = wb_dat_width'(index_q);
            adr_param_addr:   s_wb_dat_o = cfg_q.addr;
            adr_param_stride: s_wb_dat_o = wb_dat_width'(cfg_q.stride);
            adr_param_width:  s_wb_dat_o = wb_dat_width'(cfg_q.width);
            adr_param_height: s_wb_dat_o = wb_dat_width'(cfg_q.height);
            adr_param_arlen:  s_wb_dat_o = wb_dat_width'(cfg_q.arlen);
            default:          s_wb_dat_o = '0;
        endcase
    end

    assign s_wb_ack_o = s_wb_stb_i;
    assign enable_o   = ctl_q[ctl_bit_enable];
    assign update_o   = ctl_q[ctl_bit_update];
    assign cfg_o      = cfg_q;
    assign irq_o      = irq_q;

endmodule

/* source/vdma_addr_gen.sv */
// video dma read address generator

`timescale 1ns/10ps

module vdma_addr_gen (
    input  logic                     s_wb_clk_i,
    input  logic                     s_wb_rst_i,
    input  logic                     enable_i,
    input  logic                     update_i,
    input  vdma_bus_pkg::frame_cfg_t cfg_i,
    input  logic                     frame_done_i,
    output logic                     busy_o,
    output logic                     frame_start_o,
    output vdma_bus_pkg::frame_cfg_t frame_o,
    output vdma_bus_pkg::axi_ar_t    ar_o,
    input  logic                     arready_i
);
    import vdma_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_addr,
        st_wait,
        st_done
    } state_t;

    state_t                state_q;
    frame_cfg_t            frame_q;
    logic [addr_width-1:0] line_addr_q;
    logic [addr_width-1:0] araddr_q;
    logic [h_width-1:0]    remain_q;
    logic [v_width-1:0]    line_q;
    logic [len_width-1:0]  burst_len;
    logic [h_width-1:0]    burst_words;
    logic                  line_end;
    logic                  frame_end;

    // burst is clipped to the words left in the line
    always_comb begin
        if (remain_q > h_width'(frame_q.arlen)) begin
            burst_len = frame_q.arlen;
        end else begin
            burst_len = len_width'(remain_q - 1'b1);
        end
        burst_words = h_width'(burst_len) + 1'b1;
        line_end    = (remain_q == burst_words);
        frame_end   = line_end && (line_q == frame_q.height - 1'b1);
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle:  if (enable_i) state_q <= st_start;
                st_start: state_q <= st_addr;
                st_addr:  if (arready_i && frame_end) state_q <= st_wait;
                st_wait:  if (frame_done_i) state_q <= st_done;
                st_done:  state_q <= enable_i ? st_start : st_idle;
                default:  state_q <= st_idle;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    //  geometry latch and line walk
    // ------------------------------------------------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        // new geometry from idle, or when update is pending at frame end
        if ((state_q == st_idle && enable_i) ||
            (state_q == st_wait && frame_done_i && update_i)) begin
            frame_q <= cfg_i;
        end

        if (state_q == st_start) begin
            line_q      <= '0;
            line_addr_q <= frame_q.addr;
            araddr_q    <= frame_q.addr;
            remain_q    <= frame_q.width;
        end else if (state_q == st_addr && arready_i) begin
            if (line_end) begin
                line_q      <= line_q + 1'b1;
                line_addr_q <= line_addr_q + addr_width'(frame_q.stride);
                araddr_q    <= line_addr_q + addr_width'(frame_q.stride);
                remain_q    <= frame_q.width;
            end else begin
                remain_q <= remain_q - burst_words;
                araddr_q <= araddr_q + (addr_width'(burst_words) << data_size);
            end
        end
    end

    always_comb begin
        ar_o.araddr  = araddr_q;
        ar_o.arlen   = burst_len;
        ar_o.arvalid = (state_q == st_addr);
    end

    assign busy_o        = (state_q != st_idle);
    assign frame_start_o = (state_q == st_start);
    assign frame_o       = frame_q;

endmodule

/* source/vdma_stream_out.sv */
// video dma stream output stage

`timescale 1ns/10ps

module vdma_stream_out (
    input  logic                     s_wb_clk_i,
    input  logic                     s_wb_rst_i,
    input  logic                     frame_start_i,
    input  vdma_bus_pkg::frame_cfg_t frame_i,
    input  vdma_bus_pkg::axi_r_t     r_i,
    input  logic                     tready_i,
    output logic                     rready_o,
    output vdma_bus_pkg::axis_t      axis_o,
    output logic                     frame_done_o
);
    import vdma_bus_pkg::*;

    logic [h_width-1:0] width_q;
    logic [v_width-1:0] height_q;
    logic [h_width-1:0] x_q;
    logic [v_width-1:0] y_q;
    logic               done_q;
    logic               beat;
    logic               last_x;
    logic               last_y;

    assign beat   = r_i.rvalid & tready_i;
    assign last_x = (x_q == width_q - 1'b1);
    assign last_y = (y_q == height_q - 1'b1);

    always_ff @(posedge s_wb_clk_i) begin
        if (frame_start_i) begin
            width_q  <= frame_i.width;
            height_q <= frame_i.height;
        end
    end

    // pixel position within the frame
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            x_q    <= '0;
            y_q    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= beat & last_x & last_y;
            if (frame_start_i) begin
                x_q <= '0;
                y_q <= '0;
            end else if (beat) begin
                if (last_x) begin
                    x_q <= '0;
                    y_q <= last_y ? '0 : y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        axis_o.tdata  = r_i.rdata;
        axis_o.tuser  = (x_q == '0) && (y_q == '0);
        axis_o.tlast  = last_x;
        axis_o.tvalid = r_i.rvalid;
    end

    assign rready_o     = tready_i;
    assign frame_done_o = done_q;

endmodule

/* source/vdma_axi4_to_axi4s.sv */
// video dma reader top level

`timescale 1ns/10ps

module vdma_axi4_to_axi4s (
    input  logic                                  s_wb_clk_i,
    input  logic                                  s_wb_rst_i,
    input  logic [vdma_reg_pkg::wb_adr_width-1:0] s_wb_adr_i,
    input  logic [vdma_reg_pkg::wb_dat_width-1:0] s_wb_dat_i,
    output logic [vdma_reg_pkg::wb_dat_width-1:0] s_wb_dat_o,
    input  logic                                  s_wb_we_i,
    input  logic [vdma_reg_pkg::wb_sel_width-1:0] s_wb_sel_i,
    input  logic                                  s_wb_stb_i,
    output logic                                  s_wb_ack_o,

    output vdma_bus_pkg::axi_ar_t                 m_axi4_ar_o,
    input  logic                                  m_axi4_arready_i,
    output logic [2:0]                            m_axi4_arsize_o,
    output logic [1:0]                            m_axi4_arburst_o,
    output logic [3:0]                            m_axi4_arcache_o,
    output logic [0:0]                            m_axi4_arlock_o,
    output logic [2:0]                            m_axi4_arprot_o,
    output logic [3:0]                            m_axi4_arqos_o,
    output logic [3:0]                            m_axi4_arregion_o,
    input  vdma_bus_pkg::axi_r_t                  m_axi4_r_i,
    output logic                                  m_axi4_rready_o,

    output vdma_bus_pkg::axis_t                   m_axi4s_o,
    input  logic                                  m_axi4s_tready_i,
    output logic                                  out_irq_o
);
    import vdma_bus_pkg::*;

    logic       enable;
    logic       update;
    logic       busy;
    logic       frame_start;
    logic       frame_done;
    frame_cfg_t cfg;
    frame_cfg_t frame;

    assign m_axi4_arsize_o   = ar_size;
    assign m_axi4_arburst_o  = ar_burst;
    assign m_axi4_arcache_o  = ar_cache;
    assign m_axi4_arlock_o   = ar_lock;
    assign m_axi4_arprot_o   = ar_prot;
    assign m_axi4_arqos_o    = ar_qos;
    assign m_axi4_arregion_o = ar_region;

    vdma_regs i_regs (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .s_wb_adr_i   (s_wb_adr_i),
        .s_wb_dat_i   (s_wb_dat_i),
        .s_wb_dat_o   (s_wb_dat_o),
        .s_wb_we_i    (s_wb_we_i),
        .s_wb_sel_i   (s_wb_sel_i),
        .s_wb_stb_i   (s_wb_stb_i),
        .s_wb_ack_o   (s_wb_ack_o),
        .busy_i       (busy),
        .frame_done_i (frame_done),
        .enable_o     (enable),
        .update_o     (update),
        .cfg_o        (cfg),
        .irq_o        (out_irq_o)
    );

    vdma_addr_gen i_addr_gen (
        .s_wb_clk_i    (s_wb_clk_i),
        .s_wb_rst_i    (s_wb_rst_i),
        .enable_i      (enable),
        .update_i      (update),
        .cfg_i         (cfg),
        .frame_done_i  (frame_done),
        .busy_o        (busy),
        .frame_start_o (frame_start),
        .frame_o       (frame),
        .ar_o          (m_axi4_ar_o),
        .arready_i     (m_axi4_arready_i)
    );

    vdma_stream_out i_stream_out (
        .s_wb_clk_i    (s_wb_clk_i),
        .s_wb_rst_i    (s_wb_rst_i),
        .frame_start_i (frame_start),
        .frame_i       (frame),
        .r_i           (m_axi4_r_i),
        .tready_i      (m_axi4s_tready_i),
        .rready_o      (m_axi4_rready_o),
        .axis_o        (m_axi4s_o),
        .frame_done_o  (frame_done)
    );

endmodule

/* dv/vdma_assertions.sv */
// video dma handshake assertions

`timescale 1ns/10ps

module vdma_assertions (
    input logic                  s_wb_clk_i,
    input logic                  s_wb_rst_i,
    input vdma_bus_pkg::axi_ar_t ar_i,
    input logic                  arready_i,
    input vdma_bus_pkg::axis_t   axis_i,
    input logic                  tready_i,
    input logic                  irq_i
);
    // read address held until accepted
    ar_stable: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        ar_i.arvalid && !arready_i |=>
            ar_i.arvalid && $stable(ar_i.araddr) && $stable(ar_i.arlen))
        else $error("read address changed while waiting for arready");

    // stream beat held until accepted
    axis_stable: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        axis_i.tvalid && !tready_i |=>
            axis_i.tvalid && $stable(axis_i.tdata) && $stable(axis_i.tuser)
            && $stable(axis_i.tlast))
        else $error("stream beat changed while waiting for tready");

    irq_single: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        irq_i |=> !irq_i)
        else $error("interrupt high for more than one cycle");

endmodule

/* dv/tb_vdma_axi4_to_axi4s.sv */
// video dma reader testbench

`timescale 1ns/10ps

module tb_vdma_axi4_to_axi4s;
    import vdma_reg_pkg::*;
    import vdma_bus_pkg::*;

    typedef struct packed {
        frame_cfg_t cfg;
        logic       oneshot;
    } row_t;

    localparam int num_rows = 4;
    localparam logic [31:0] ctl_enable  = 32'(1) << ctl_bit_enable;
    localparam logic [31:0] ctl_update  = 32'(1) << ctl_bit_update;
    localparam logic [31:0] ctl_oneshot = 32'(1) << ctl_bit_oneshot;

    logic        wb_clk;
    logic        wb_rst;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_ack;
    axi_ar_t     ar;
    logic        arready;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic [3:0]  arcache;
    logic [0:0]  arlock;
    logic [2:0]  arprot;
    logic [3:0]  arqos;
    logic [3:0]  arregion;
    axi_r_t      r;
    logic        rready;
    axis_t       axis;
    logic        tready;
    logic        irq;

    row_t                  rows [num_rows];
    frame_cfg_t            exp_q [$];
    logic [addr_width-1:0] burst_addr [$];
    logic [len_width-1:0]  burst_len [$];
    logic [31:0]           lfsr_q;
    int beat_idx, pos_x, pos_y, frames_seen, frames_total, irq_count;
    int cycle_count, cycle_limit, value_errors, other_errors;

    always #20 wb_clk = ~wb_clk;

    vdma_axi4_to_axi4s i_dut (
        .s_wb_clk_i        (wb_clk),
        .s_wb_rst_i        (wb_rst),
        .s_wb_adr_i        (wb_adr),
        .s_wb_dat_i        (wb_dat_w),
        .s_wb_dat_o        (wb_dat_r),
        .s_wb_we_i         (wb_we),
        .s_wb_sel_i        (wb_sel),
        .s_wb_stb_i        (wb_stb),
        .s_wb_ack_o        (wb_ack),
        .m_axi4_ar_o       (ar),
        .m_axi4_arready_i  (arready),
        .m_axi4_arsize_o   (arsize),
        .m_axi4_arburst_o  (arburst),
        .m_axi4_arcache_o  (arcache),
        .m_axi4_arlock_o   (arlock),
        .m_axi4_arprot_o   (arprot),
        .m_axi4_arqos_o    (arqos),
        .m_axi4_arregion_o (arregion),
        .m_axi4_r_i        (r),
        .m_axi4_rready_o   (rready),
        .m_axi4s_o         (axis),
        .m_axi4s_tready_i  (tready),
        .out_irq_o         (irq)
    );

    bind vdma_axi4_to_axi4s vdma_assertions i_assertions (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .ar_i       (m_axi4_ar_o),
        .arready_i  (m_axi4_arready_i),
        .axis_i     (m_axi4s_o),
        .tready_i   (m_axi4s_tready_i),
        .irq_i      (out_irq_o)
    );

    // 32 bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic random_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic row_t make_row(input logic [31:0] addr, input int stride, width,
                                      height, arlen, input logic oneshot);
        row_t row;
        row.cfg.addr   = addr;
        row.cfg.stride = stride_width'(stride);
        row.cfg.width  = h_width'(width);
        row.cfg.height = v_width'(height);
        row.cfg.arlen  = len_width'(arlen);
        row.oneshot    = oneshot;
        return row;
    endfunction

    function automatic int frame_size(input frame_cfg_t g);
        return int'(g.width) * int'(g.height);
    endfunction

    // ------------------------------------------------------------------------
    //  wishbone access starting and ending 2 ns after a clock edge
    // ------------------------------------------------------------------------
    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = 1'b1;
        wb_stb   = 1'b1;
        @(posedge wb_clk);
        if (wb_ack !== 1'b1) begin
            other_errors++;
            $display("wishbone write at %0t was not acknowledged", $time);
        end
        #2;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        @(posedge wb_clk);
        got = wb_dat_r;
        if (wb_ack !== 1'b1) begin
            other_errors++;
            $display("wishbone read of %s at %0t was not acknowledged", what, $time);
        end
        #2;
        wb_stb = 1'b0;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic program_geometry(input frame_cfg_t g);
        wb_write(adr_param_addr, g.addr, 4'hf);
        wb_write(adr_param_stride, 32'(g.stride), 4'hf);
        wb_write(adr_param_width, 32'(g.width), 4'hf);
        wb_write(adr_param_height, 32'(g.height), 4'hf);
        wb_write(adr_param_arlen, 32'(g.arlen), 4'hf);
    endtask

    task automatic wait_irqs(input int n);
        while (irq_count < n) begin
            @(posedge wb_clk);
            #2;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge wb_clk);
            #2;
        end
    endtask

    // pixel data is its own byte address
    task automatic check_beat();
        frame_cfg_t  g;
        logic [31:0] exp_data;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("stream beat at %0t while no frame was expected", $time);
        end else begin
            g        = exp_q[0];
            exp_data = g.addr + 32'(pos_y) * 32'(g.stride) + 32'(4 * pos_x);
            if (axis.tdata !== exp_data) begin
                value_errors++;
                $display("[FAIL] %0t: pixel (%0d,%0d) data %h, expected %h", $time,
                         pos_x, pos_y, axis.tdata, exp_data);
            end
            if (axis.tuser !== (pos_x == 0 && pos_y == 0) ||
                axis.tlast !== (pos_x == int'(g.width) - 1)) begin
                value_errors++;
                $display("[FAIL] %0t: pixel (%0d,%0d) has tuser %b tlast %b", $time,
                         pos_x, pos_y, axis.tuser, axis.tlast);
            end
            if (pos_x == int'(g.width) - 1) begin
                pos_x = 0;
                if (pos_y == int'(g.height) - 1) begin
                    pos_y = 0;
                    void'(exp_q.pop_front());
                    frames_seen++;
                end else begin
                    pos_y++;
                end
            end else begin
                pos_x++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    //  in-order read memory, stream sink and irq counter
    // ------------------------------------------------------------------------
    always @(posedge wb_clk) begin
        logic stalled;
        stalled = r.rvalid && !rready;
        if (ar.arvalid && arready) begin
            burst_addr.push_back(ar.araddr);
            burst_len.push_back(ar.arlen);
            // incr bursts of whole words, bufferable, no lock or protection
            if (arsize !== 3'(data_size) || arburst !== 2'b01 || arcache !== 4'b0001
                || arlock !== 1'b0 || arprot !== 3'b000 || arqos !== 4'b0000
                || arregion !== 4'b0000) begin
                value_errors++;
                $display("[FAIL] %0t: burst size %h burst %h cache %h lock %h", $time,
                         arsize, arburst, arcache, arlock);
                $display("[FAIL] %0t: burst prot %h qos %h region %h", $time,
                         arprot, arqos, arregion);
            end
        end
        if (axis.tvalid && tready) begin
            check_beat();
        end
        if (r.rvalid && rready) begin
            if (r.rlast) begin
                void'(burst_addr.pop_front());
                void'(burst_len.pop_front());
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
        if (irq) begin
            irq_count++;
        end
        #2;
        arready = random_bit();
        if (!stalled) begin
            if (burst_addr.size() != 0 && (random_bit() | random_bit())) begin
                r.rvalid = 1'b1;
                r.rdata  = burst_addr[0] + 32'(4 * beat_idx);
                r.rlast  = (beat_idx == int'(burst_len[0]));
            end else begin
                r = '0;
            end
        end
        tready = random_bit() | random_bit();
    end

    always @(posedge wb_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, a frame never completed", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        frame_cfg_t nxt;
        int         n;
        wb_clk = 1'b0;
        wb_rst = 1'b1;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_we = 1'b0;
        wb_sel = '0;
        wb_stb = 1'b0;
        arready = 1'b0;
        r = '0;
        tready = 1'b0;
        lfsr_q = 32'd80614;
        beat_idx = 0;
        pos_x = 0;
        pos_y = 0;
        frames_seen = 0;
        frames_total = 0;
        irq_count = 0;
        cycle_count = 0;
        value_errors = 0;
        other_errors = 0;

        // addr, stride, width, height, arlen, one-shot
        rows[0] = make_row(32'h0000_1000, 64, 16, 4, 3, 1'b1);
        rows[1] = make_row(32'h0002_0000, 128, 13, 3, 4, 1'b1);
        rows[2] = make_row(32'h0003_0040, 256, 10, 5, 7, 1'b0);
        rows[3] = make_row(32'h0004_0000, 48, 7, 6, 0, 1'b1);

        cycle_limit = 200;
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].oneshot) begin
                cycle_limit += frame_size(rows[i].cfg) * 8 + 200;
            end else begin
                cycle_limit += (3 * frame_size(rows[i].cfg)
                                + frame_size(rows[(i + 1) % num_rows].cfg)) * 8 + 200;
            end
        end

        repeat (3) @(posedge wb_clk);
        #2;
        wb_rst = 1'b0;

        if (ar.arvalid || axis.tvalid || irq) begin
            other_errors++;
            $display("arvalid, tvalid or irq is high after reset");
        end
        check_reg(adr_ctl_control, 32'h0, "control after reset");
        check_reg(adr_ctl_status, 32'h0, "status after reset");
        check_reg(adr_ctl_index, 32'h0, "index after reset");

        check_reg(adr_core_id, core_id, "core id");
        check_reg(8'h02, 32'h0, "unmapped 0x02");
        check_reg(8'h3f, 32'h0, "unmapped 0x3f");
        wb_write(adr_param_width, 32'h0000_0abc, 4'hf);
        wb_write(adr_param_width, 32'h0000_0055, 4'b0001);
        check_reg(adr_param_width, 32'h0000_0a55, "width after byte 0 write");
        wb_write(adr_param_addr, 32'h1234_5678, 4'hf);
        wb_write(adr_param_addr, 32'hffff_ffff, 4'b1000);
        check_reg(adr_param_addr, 32'hff34_5678, "addr after byte 3 write");
        wb_write(adr_param_addr, 32'h0000_1003, 4'hf);
        check_reg(adr_param_addr, 32'h0000_1000, "unaligned addr");
        wb_write(adr_param_stride, 32'h0000_0043, 4'hf);
        check_reg(adr_param_stride, 32'h0000_0040, "unaligned stride");

        for (int i = 0; i < num_rows; i++) begin
            program_geometry(rows[i].cfg);
            n = irq_count;
            if (rows[i].oneshot) begin
                exp_q.push_back(rows[i].cfg);
                wb_write(adr_ctl_control, ctl_enable | ctl_update | ctl_oneshot, 4'hf);
                wait_irqs(n + 1);
                frames_total += 1;
                check_reg(adr_ctl_control, 32'h0, "control after one-shot");
                check_reg(adr_ctl_status, 32'h0, "status after one-shot");
                idle_cycles(20);
            end else begin
                // new geometry only takes effect two frames later, once update is set
                nxt = rows[(i + 1) % num_rows].cfg;
                exp_q.push_back(rows[i].cfg);
                exp_q.push_back(rows[i].cfg);
                exp_q.push_back(rows[i].cfg);
                exp_q.push_back(nxt);
                wb_write(adr_ctl_control, ctl_enable | ctl_update, 4'hf);
                wait_irqs(n + 1);
                program_geometry(nxt);
                wait_irqs(n + 2);
                wb_write(adr_ctl_control, ctl_enable | ctl_update, 4'hf);
                wait_irqs(n + 3);
                check_reg(adr_ctl_control, ctl_enable, "control after update");
                wb_write(adr_ctl_control, 32'h0, 4'hf);
                wait_irqs(n + 4);
                frames_total += 4;
                idle_cycles(2);
                check_reg(adr_ctl_status, 32'h0, "status after stop");
            end
            check_reg(adr_ctl_index, 32'(frames_total % 256), "frame index");
            if (exp_q.size() != 0 || frames_seen != irq_count) begin
                other_errors++;
                $display("entry %0d: %0d frames missing, %0d frames seen against %0d irqs",
                         i, exp_q.size(), frames_seen, irq_count);
            end
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/vdma_reg_pkg.sv
source/vdma_bus_pkg.sv
source/vdma_regs.sv
source/vdma_addr_gen.sv
source/vdma_stream_out.sv
source/vdma_axi4_to_axi4s.sv
dv/vdma_assertions.sv
dv/tb_vdma_axi4_to_axi4s.sv

/* Bender.yml */
package:
  name: vdma_axi4_to_axi4s

sources:
  - source/vdma_reg_pkg.sv
  - source/vdma_bus_pkg.sv
  - source/vdma_regs.sv
  - source/vdma_addr_gen.sv
  - source/vdma_stream_out.sv
  - source/vdma_axi4_to_axi4s.sv
  - target: test
    files:
      - dv/vdma_assertions.sv
      - dv/tb_vdma_axi4_to_axi4s.sv
